//--- mac_package.sv
/*
 * mac accelerator shared definitions
 * Widths, register map, data types, control structs and FSM states
 * used by the register slave, the FSM and the engine.
 */
package mac_package;

  localparam int unsigned MAC_ADDR_W  = 8;
  localparam int unsigned MAC_DATA_W  = 32;
  localparam int unsigned MAC_OP_W    = 16;
  localparam int unsigned MAC_ACC_W   = 32;
  localparam int unsigned MAC_ITER_W  = 17;  // up to 65536 iterations
  localparam int unsigned MAC_SHIFT_W = 5;
  localparam int unsigned MAC_CNT_LEN = 256;  // longest iteration in pairs
  localparam int unsigned MAC_LEN_W   = $clog2(MAC_CNT_LEN) + 1;

  typedef logic        [MAC_DATA_W-1:0]  reg_word_t;
  typedef logic        [MAC_ADDR_W-1:0]  addr_t;
  typedef logic signed [MAC_OP_W-1:0]    operand_t;
  typedef logic signed [MAC_ACC_W-1:0]   acc_t;
  typedef logic        [MAC_LEN_W-1:0]   len_t;
  typedef logic        [MAC_ITER_W-1:0]  iter_t;
  typedef logic        [MAC_SHIFT_W-1:0] shift_t;

  // register map, byte offsets
  localparam addr_t MAC_REG_TRIGGER         = 8'h00;
  localparam addr_t MAC_REG_STATUS          = 8'h04;
  localparam addr_t MAC_REG_SOFT_CLEAR      = 8'h08;
  localparam addr_t MAC_REG_NB_ITER         = 8'h10;
  localparam addr_t MAC_REG_LEN_ITER        = 8'h14;
  localparam addr_t MAC_REG_SHIFT_SIMPLEMUL = 8'h18;

  typedef struct packed {
    logic      req;
    logic      we;
    addr_t     addr;
    reg_word_t wdata;
  } periph_req_t;

  typedef struct packed {
    reg_word_t rdata;
    logic      rvalid;
  } periph_rsp_t;

  typedef struct packed {
    iter_t  nb_iter;
    len_t   len;
    shift_t shift;
    logic   simple_mul;
  } mac_cfg_t;

  typedef struct packed {
    logic   start;  // one cycle, clears the engine counters
    logic   enable;
    len_t   len;
    shift_t shift;
    logic   simple_mul;
  } ctrl_engine_t;

  typedef struct packed {
    logic iter_done;
  } flags_engine_t;

  typedef struct packed {
    logic done;
    logic busy;
  } ctrl_slave_t;

  typedef struct packed {
    operand_t a;
    operand_t b;
    logic     valid;
  } stream_in_t;

  typedef struct packed {
    acc_t data;
    logic valid;
  } stream_out_t;

  typedef enum logic [1:0] {
    FSM_IDLE,
    FSM_START,
    FSM_COMPUTE,
    FSM_TERMINATE
  } fsm_state_t;

endpackage

//--- mac_regfile.sv
/*
 * mac register slave
 * Holds the job configuration, turns trigger and soft-clear writes into
 * pulses, answers reads one cycle later and raises the done event.
 */
`timescale 1ns/1ps

module mac_regfile import mac_package::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  periph_req_t periph_req_i,
  output periph_rsp_t periph_rsp_o,
  input  ctrl_slave_t ctrl_i,
  output logic        clear_o,
  output logic        start_o,
  output logic        evt_o,
  output reg_word_t   nb_iter_o,
  output reg_word_t   len_iter_o,
  output reg_word_t   shift_simplemul_o
);

  logic      wr_en;
  logic      rd_en;
  reg_word_t nb_iter_q;
  reg_word_t len_iter_q;
  reg_word_t shift_simplemul_q;
  reg_word_t rdata_d;
  reg_word_t rdata_q;
  logic      rvalid_q;
  logic      evt_q;

  assign wr_en = periph_req_i.req & periph_req_i.we;
  assign rd_en = periph_req_i.req & ~periph_req_i.we;

  // a trigger while a job runs is simply dropped
  assign start_o = wr_en & (periph_req_i.addr == MAC_REG_TRIGGER) & ~ctrl_i.busy;
  assign clear_o = wr_en & (periph_req_i.addr == MAC_REG_SOFT_CLEAR);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nb_iter_q         <= '0;
      len_iter_q        <= '0;
      shift_simplemul_q <= '0;
    end else if (clear_o) begin
      nb_iter_q         <= '0;
      len_iter_q        <= '0;
      shift_simplemul_q <= '0;
    end else if (wr_en) begin
      case (periph_req_i.addr)
        MAC_REG_NB_ITER:         nb_iter_q         <= periph_req_i.wdata;
        MAC_REG_LEN_ITER:        len_iter_q        <= periph_req_i.wdata;
        MAC_REG_SHIFT_SIMPLEMUL: shift_simplemul_q <= periph_req_i.wdata;
        default: ;  // trigger and clear are pulses only
      endcase
    end
  end

  always_comb begin
    rdata_d = '0;  // unmapped offsets read as zero
    case (periph_req_i.addr)
      MAC_REG_STATUS:          rdata_d[0] = ctrl_i.busy;
      MAC_REG_NB_ITER:         rdata_d    = nb_iter_q;
      MAC_REG_LEN_ITER:        rdata_d    = len_iter_q;
      MAC_REG_SHIFT_SIMPLEMUL: rdata_d    = shift_simplemul_q;
      default:                 rdata_d    = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  // event follows the FSM done pulse by one cycle, a clear cancels it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      evt_q <= 1'b0;
    end else begin
      evt_q <= ctrl_i.done & ~clear_o;
    end
  end

  assign periph_rsp_o.rdata  = rdata_q;
  assign periph_rsp_o.rvalid = rvalid_q;
  assign evt_o               = evt_q;
  assign nb_iter_o           = nb_iter_q;
  assign len_iter_o          = len_iter_q;
  assign shift_simplemul_o   = shift_simplemul_q;

endmodule

//--- mac_fsm.sv
/*
 * mac main FSM
 * Latches the job configuration, runs the engine for nb_iter
 * iterations and signals completion back to the register slave.
 */
`timescale 1ns/1ps

module mac_fsm import mac_package::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  input  logic          start_i,
  input  mac_cfg_t      cfg_i,
  output ctrl_engine_t  ctrl_engine_o,
  input  flags_engine_t flags_engine_i,
  output ctrl_slave_t   ctrl_slave_o
);

  fsm_state_t state_q;
  fsm_state_t state_d;
  mac_cfg_t   cfg_q;
  iter_t      iter_cnt_q;
  iter_t      iter_cnt_nxt;
  logic       last_iter;

  assign iter_cnt_nxt = iter_cnt_q + iter_t'(1);
  assign last_iter    = flags_engine_i.iter_done & (iter_cnt_nxt == cfg_q.nb_iter);

  always_comb begin
    state_d = state_q;
    case (state_q)
      FSM_IDLE: begin
        if (start_i) begin
          state_d = FSM_START;
        end
      end
      FSM_START: begin
        state_d = FSM_COMPUTE;
      end
      FSM_COMPUTE: begin
        if (last_iter) begin
          state_d = FSM_TERMINATE;
        end
      end
      FSM_TERMINATE: begin
        state_d = FSM_IDLE;
      end
      default: begin
        state_d = FSM_IDLE;
      end
    endcase
    if (clear_i) begin
      state_d = FSM_IDLE;  // soft clear aborts any running job
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= FSM_IDLE;
      cfg_q      <= '0;
      iter_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FSM_START) begin
        cfg_q      <= cfg_i;  // later register writes leave this job alone
        iter_cnt_q <= '0;
      end else if (state_q == FSM_COMPUTE && flags_engine_i.iter_done) begin
        iter_cnt_q <= iter_cnt_nxt;
      end
    end
  end

  always_comb begin
    ctrl_engine_o.start      = (state_q == FSM_START);
    ctrl_engine_o.enable     = (state_q == FSM_COMPUTE);
    ctrl_engine_o.len        = cfg_q.len;
    ctrl_engine_o.shift      = cfg_q.shift;
    ctrl_engine_o.simple_mul = cfg_q.simple_mul;
    ctrl_slave_o.done        = (state_q == FSM_TERMINATE);
    ctrl_slave_o.busy        = (state_q != FSM_IDLE);
  end

endmodule

//--- mac_ctrl.sv
/*
 * mac control block
 * Wraps the register slave and the main FSM and maps the raw
 * configuration registers onto the decoded job configuration.
 */
`timescale 1ns/1ps

module mac_ctrl import mac_package::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  periph_req_t   periph_req_i,
  output periph_rsp_t   periph_rsp_o,
  output logic          clear_o,
  output logic          evt_o,
  output ctrl_engine_t  ctrl_engine_o,
  input  flags_engine_t flags_engine_i
);

  ctrl_slave_t slave_ctrl;
  logic        slave_start;
  reg_word_t   reg_nb_iter;
  reg_word_t   reg_len_iter;
  reg_word_t   reg_shift_simplemul;
  mac_cfg_t    fsm_cfg;

  mac_regfile i_regfile (
    .clk_i             ( clk_i               ),
    .rst_n_i           ( rst_n_i             ),
    .periph_req_i      ( periph_req_i        ),
    .periph_rsp_o      ( periph_rsp_o        ),
    .ctrl_i            ( slave_ctrl          ),
    .clear_o           ( clear_o             ),
    .start_o           ( slave_start         ),
    .evt_o             ( evt_o               ),
    .nb_iter_o         ( reg_nb_iter         ),
    .len_iter_o        ( reg_len_iter        ),
    .shift_simplemul_o ( reg_shift_simplemul )
  );

  // registers hold count minus one, so zero means a single iteration or pair
  always_comb begin
    fsm_cfg.nb_iter    = iter_t'(reg_nb_iter[15:0]) + iter_t'(1);
    fsm_cfg.len        = len_t'(reg_len_iter[7:0]) + len_t'(1);
    fsm_cfg.shift      = reg_shift_simplemul[20:16];
    fsm_cfg.simple_mul = reg_shift_simplemul[0];
  end

  mac_fsm i_fsm (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .clear_i        ( clear_o        ),
    .start_i        ( slave_start    ),
    .cfg_i          ( fsm_cfg        ),
    .ctrl_engine_o  ( ctrl_engine_o  ),
    .flags_engine_i ( flags_engine_i ),
    .ctrl_slave_o   ( slave_ctrl     )
  );

endmodule

//--- mac_engine.sv
/*
 * mac engine
 * Multiplies operand pairs, optionally sums them over an iteration,
 * shifts the result and emits it as a one-cycle strobe.
 */
`timescale 1ns/1ps

module mac_engine import mac_package::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  input  ctrl_engine_t  ctrl_i,
  output flags_engine_t flags_o,
  input  stream_in_t    stream_i,
  output stream_out_t   stream_o
);

  operand_t op_a;
  operand_t op_b;
  acc_t     product;
  acc_t     sum_q;
  acc_t     sum_nxt;
  acc_t     unshifted;
  acc_t     result;
  len_t     cnt_q;
  logic     accept;
  logic     last_pair;
  acc_t     data_q;
  logic     valid_q;
  logic     iter_done_q;

  assign op_a    = stream_i.a;
  assign op_b    = stream_i.b;
  assign accept  = stream_i.valid & ctrl_i.enable;  // pairs outside a job are dropped
  assign product = acc_t'(op_a) * acc_t'(op_b);

  assign last_pair = (cnt_q == ctrl_i.len - len_t'(1));
  assign sum_nxt   = sum_q + product;  // wraps at 32 bits
  assign unshifted = ctrl_i.simple_mul ? product : sum_nxt;
  assign result    = unshifted >>> ctrl_i.shift;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q       <= '0;
      sum_q       <= '0;
      valid_q     <= 1'b0;
      iter_done_q <= 1'b0;
    end else if (clear_i || ctrl_i.start) begin
      cnt_q       <= '0;
      sum_q       <= '0;
      valid_q     <= 1'b0;
      iter_done_q <= 1'b0;
    end else begin
      valid_q     <= accept & (ctrl_i.simple_mul | last_pair);
      iter_done_q <= accept & last_pair;
      if (accept) begin
        if (last_pair) begin
          cnt_q <= '0;  // iteration boundary restarts the dot product
          sum_q <= '0;
        end else begin
          cnt_q <= cnt_q + len_t'(1);
          sum_q <= sum_nxt;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= result;
    end
  end

  assign stream_o.data     = data_q;
  assign stream_o.valid    = valid_q;
  assign flags_o.iter_done = iter_done_q;

endmodule

//--- mac_top.sv
/*
 * mac accelerator top level
 * Connects the control block and the engine to the register port
 * and the operand and result streams.
 */
`timescale 1ns/1ps

module mac_top import mac_package::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  periph_req_t periph_req_i,
  output periph_rsp_t periph_rsp_o,
  output logic        evt_o,
  input  stream_in_t  stream_i,
  output stream_out_t stream_o
);

  logic          clear;
  ctrl_engine_t  ctrl_engine;
  flags_engine_t flags_engine;

  mac_ctrl i_ctrl (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .periph_req_i   ( periph_req_i ),
    .periph_rsp_o   ( periph_rsp_o ),
    .clear_o        ( clear        ),
    .evt_o          ( evt_o        ),
    .ctrl_engine_o  ( ctrl_engine  ),
    .flags_engine_i ( flags_engine )
  );

  mac_engine i_engine (
    .clk_i    ( clk_i        ),
    .rst_n_i  ( rst_n_i      ),
    .clear_i  ( clear        ),
    .ctrl_i   ( ctrl_engine  ),
    .flags_o  ( flags_engine ),
    .stream_i ( stream_i     ),
    .stream_o ( stream_o     )
  );

endmodule

//--- tb_mac_top.sv
/*
 * testbench for the mac accelerator
 * Runs seeded random jobs through the register port and operand stream
 * and checks every result and event against a reference model.
 */
`timescale 1ns/1ps

module tb_mac_top import mac_package::*; ();

  localparam int JOB_PAIRS_MAX  = 3 * 256;  // largest nb_iter times len used below
  localparam int JOBS           = 6;
  localparam int PAIR_CYCLES    = 4;  // one strobe plus the longest gap
  localparam int REG_ACCESSES   = 120;
  localparam int TIMEOUT_CYCLES = 10 + JOBS * JOB_PAIRS_MAX * PAIR_CYCLES +
                                  REG_ACCESSES * 3 + 500;

  logic        clk;
  logic        rst_n;
  periph_req_t periph_req;
  periph_rsp_t periph_rsp;
  logic        evt;
  stream_in_t  stream_in;
  stream_out_t stream_out;
  integer      seed = 78698;
  int          exp_q[$];  // expected results in arrival order
  int          exp_val;
  int          evt_cnt;
  bit          pairs_active;
  addr_t       cfg_addrs [3] = '{MAC_REG_NB_ITER, MAC_REG_LEN_ITER, MAC_REG_SHIFT_SIMPLEMUL};
  addr_t       unmapped_addrs [4] = '{8'h0c, 8'h1c, 8'h20, 8'hfc};

  mac_top dut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .periph_req_i ( periph_req ),
    .periph_rsp_o ( periph_rsp ),
    .evt_o        ( evt        ),
    .stream_i     ( stream_in  ),
    .stream_o     ( stream_out )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $fatal(1);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // results and events are sampled one edge after the DUT registers them
  always @(posedge clk) begin
    if (rst_n && stream_out.valid) begin
      if (exp_q.size() == 0) begin
        report_error("stream_o delivered a result that no running job expects");
      end else begin
        exp_val = exp_q.pop_front();
        check_value("stream_o.data", stream_out.data, exp_val);
      end
    end
    if (rst_n && evt) begin
      if (exp_q.size() != 0) begin
        report_error("evt_o pulsed while results of the job were still missing");
      end else begin
        evt_cnt++;
      end
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    rand_range = lo + ((r & 32'h7fffffff) % (hi - lo + 1));
  endfunction

  function automatic operand_t pick_op(input bit extreme);
    int r;
    r = rand_range(0, 3);
    if (extreme && r == 0) begin
      pick_op = operand_t'(-32768);
    end else if (extreme && r == 1) begin
      pick_op = operand_t'(32767);
    end else begin
      pick_op = operand_t'($random(seed));
    end
  endfunction

  task automatic write_reg(input addr_t addr, input reg_word_t data);
    @(posedge clk);
    periph_req <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    periph_req <= '0;
  endtask

  task automatic read_reg(input addr_t addr, output reg_word_t data);
    @(posedge clk);
    periph_req <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge clk);
    periph_req <= '0;
    check_value("rvalid on request cycle", 32'(periph_rsp.rvalid), 32'd0);
    @(posedge clk);
    check_value("rvalid one cycle later", 32'(periph_rsp.rvalid), 32'd1);
    data = periph_rsp.rdata;
  endtask

  task automatic drive_pair(input operand_t a, input operand_t b);
    @(posedge clk);
    stream_in <= '{a: a, b: b, valid: 1'b1};
  endtask

  task automatic idle_stream();
    @(posedge clk);
    stream_in.valid <= 1'b0;
  endtask

  // pairs sent while no job runs must vanish
  task automatic send_junk(input int n);
    repeat (n) drive_pair(pick_op(1'b0), pick_op(1'b0));
    idle_stream();
  endtask

  task automatic run_job(input int nb, input int len, input int sh, input bit simple,
                         input bit extreme, input int max_gap, input bit disturb);
    operand_t  pa[$];
    operand_t  pb[$];
    operand_t  a;
    operand_t  b;
    int        acc;
    int        p;
    int        evt_before;
    reg_word_t rd;
    write_reg(MAC_REG_NB_ITER, reg_word_t'(nb - 1));
    write_reg(MAC_REG_LEN_ITER, reg_word_t'(len - 1));
    write_reg(MAC_REG_SHIFT_SIMPLEMUL, {11'd0, shift_t'(sh), 15'd0, simple});
    send_junk(3);
    for (int it = 0; it < nb; it++) begin
      acc = 0;
      for (int k = 0; k < len; k++) begin
        a = pick_op(extreme);
        b = pick_op(extreme);
        pa.push_back(a);
        pb.push_back(b);
        p = int'(a) * int'(b);
        acc = acc + p;  // int arithmetic wraps at 32 bits like the accumulator
        if (simple) begin
          exp_q.push_back(p >>> sh);
        end
      end
      if (!simple) begin
        exp_q.push_back(acc >>> sh);
      end
    end
    evt_before = evt_cnt;
    write_reg(MAC_REG_TRIGGER, 32'd1);
    pairs_active = 1'b1;
    fork
      begin
        for (int i = 0; i < pa.size(); i++) begin
          drive_pair(pa[i], pb[i]);
          repeat (rand_range(0, max_gap)) idle_stream();
        end
        idle_stream();
        pairs_active = 1'b0;
      end
      begin
        if (disturb) begin
          write_reg(MAC_REG_TRIGGER, 32'd1);  // must not restart the job
          write_reg(MAC_REG_NB_ITER, 32'd0);
          write_reg(MAC_REG_LEN_ITER, 32'd0);
          write_reg(MAC_REG_SHIFT_SIMPLEMUL, 32'h001f_0001);
          while (pairs_active) begin
            read_reg(MAC_REG_STATUS, rd);
            check_value("STATUS during job", rd, 32'd1);
          end
        end
      end
    join
    while (evt_cnt == evt_before) @(posedge clk);
    send_junk(3);
    repeat (8) @(posedge clk);
    check_value("evt_o count", evt_cnt, evt_before + 1);
    check_value("pending results", exp_q.size(), 32'd0);
    read_reg(MAC_REG_STATUS, rd);
    check_value("STATUS after job", rd, 32'd0);
  endtask

  initial begin
    reg_word_t rd;
    reg_word_t val;
    int        evt_before;
    rst_n      = 1'b0;
    periph_req = '0;
    stream_in  = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    read_reg(MAC_REG_STATUS, rd);
    check_value("STATUS after reset", rd, 32'd0);
    foreach (cfg_addrs[i]) begin
      val = reg_word_t'($random(seed));
      write_reg(cfg_addrs[i], val);
      read_reg(cfg_addrs[i], rd);
      check_value("config readback", rd, val);
    end
    foreach (unmapped_addrs[i]) begin
      read_reg(unmapped_addrs[i], rd);
      check_value("unmapped readback", rd, 32'd0);
    end

    run_job(rand_range(1, 4), rand_range(1, 8), rand_range(0, 31), 1'b1, 1'b0, 3, 1'b0);
    run_job(rand_range(2, 3), rand_range(1, 256), rand_range(0, 31), 1'b0, 1'b1, 1, 1'b0);
    run_job(2, 256, 0, 1'b0, 1'b1, 0, 1'b0);
    run_job(2, rand_range(32, 64), rand_range(0, 8), 1'b0, 1'b0, 0, 1'b1);

    // soft clear in the middle of a job, then more pairs than the job still needs
    write_reg(MAC_REG_NB_ITER, 32'd2);
    write_reg(MAC_REG_LEN_ITER, 32'd19);
    write_reg(MAC_REG_SHIFT_SIMPLEMUL, 32'd0);
    evt_before = evt_cnt;
    write_reg(MAC_REG_TRIGGER, 32'd1);
    send_junk(10);
    write_reg(MAC_REG_SOFT_CLEAR, 32'd1);
    send_junk(60);
    repeat (20) @(posedge clk);
    check_value("evt_o count after clear", evt_cnt, evt_before);
    read_reg(MAC_REG_STATUS, rd);
    check_value("STATUS after clear", rd, 32'd0);
    foreach (cfg_addrs[i]) begin
      read_reg(cfg_addrs[i], rd);
      check_value("config after clear", rd, 32'd0);
    end
    run_job(2, 5, 3, 1'b0, 1'b0, 2, 1'b0);

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- mac_top.f
mac_package.sv
mac_regfile.sv
mac_fsm.sv
mac_ctrl.sv
mac_engine.sv
mac_top.sv
tb_mac_top.sv

//--- Makefile
TOP_RTL = mac_top
TOP_TB  = tb_mac_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f mac_top.f --top-module $(TOP_RTL)

sim:
	verilator --binary --timing -f mac_top.f --top-module $(TOP_TB) -o $(TOP_TB)
	@out="$$(./obj_dir/$(TOP_TB))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
